/* design/core_pkg.sv */
// Core package for the RV32 integer core
package core_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned NR_REGS    = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned ALU_OP_W   = 3;

  // ----------------------------------------
  // Encodings
  // ----------------------------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [31:0] MRET_WORD = 32'h3020_0073;

  // Function codes of the supported instructions
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  // ALU operations with PASS_B for LUI
  localparam logic [ALU_OP_W-1:0] ALU_ADD    = 3'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB    = 3'd1;
  localparam logic [ALU_OP_W-1:0] ALU_XOR    = 3'd2;
  localparam logic [ALU_OP_W-1:0] ALU_OR     = 3'd3;
  localparam logic [ALU_OP_W-1:0] ALU_AND    = 3'd4;
  localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 3'd5;

  localparam logic [XLEN-1:0] CAUSE_ILLEGAL = 32'd2;

  // Instruction word seen as R-type or I-type
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [11:0]           imm;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } i;
  } instr_t;

endpackage

/* design/fetch_unit.sv */
// Instruction fetch unit
module fetch_unit #(
  parameter logic [core_pkg::XLEN-1:0] BootAddr = '0
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      redirect_valid_i,
  input  logic [core_pkg::XLEN-1:0] redirect_pc_i,
  output logic                      instr_req_o,
  output logic [core_pkg::XLEN-1:0] instr_addr_o,
  input  logic                      instr_valid_i,
  input  logic [31:0]               instr_rdata_i,
  output logic                      fetch_valid_o,
  output logic [core_pkg::XLEN-1:0] fetch_pc_o,
  output core_pkg::instr_t          fetch_instr_o
);

  logic [core_pkg::XLEN-1:0] pc_q;
  logic                      boot_q;
  logic                      req_q;
  logic                      outstanding_q;
  logic                      accept;

  // Stray responses are dropped
  assign accept       = instr_valid_i & outstanding_q;
  assign instr_req_o  = req_q;
  assign instr_addr_o = pc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q          <= BootAddr;
      boot_q        <= 1'b1;
      req_q         <= 1'b0;
      outstanding_q <= 1'b0;
      fetch_valid_o <= 1'b0;
    end else begin
      boot_q        <= 1'b0;
      req_q         <= boot_q | redirect_valid_i;
      fetch_valid_o <= accept;
      if (redirect_valid_i) begin
        pc_q <= redirect_pc_i;
      end
      if (req_q) begin
        outstanding_q <= 1'b1;
      end else if (accept) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  // Returned word and its PC
  always_ff @(posedge clk_i) begin
    if (accept) begin
      fetch_pc_o    <= pc_q;
      fetch_instr_o <= instr_rdata_i;
    end
  end

endmodule

/* design/reg_file.sv */
// Integer register file
module reg_file (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [core_pkg::XLEN-1:0]       rdata_b_o,
  input  logic                            we_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [core_pkg::XLEN-1:0]       wdata_i
);

  // No storage behind x0
  logic [core_pkg::XLEN-1:0] regs_q [1:core_pkg::NR_REGS-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned k = 1; k < core_pkg::NR_REGS; k++) begin
        regs_q[k] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* design/decode_unit.sv */
// Instruction decode stage
module decode_unit (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            fetch_valid_i,
  input  logic [core_pkg::XLEN-1:0]       fetch_pc_i,
  input  core_pkg::instr_t                fetch_instr_i,
  output logic [core_pkg::REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rf_raddr_b_o,
  input  logic [core_pkg::XLEN-1:0]       rf_rdata_a_i,
  input  logic [core_pkg::XLEN-1:0]       rf_rdata_b_i,
  output logic                            dec_valid_o,
  output logic [core_pkg::XLEN-1:0]       dec_pc_o,
  output core_pkg::instr_t                dec_instr_o,
  output logic [core_pkg::XLEN-1:0]       dec_op_a_o,
  output logic [core_pkg::XLEN-1:0]       dec_op_b_o,
  output logic [core_pkg::XLEN-1:0]       dec_imm_o,
  output logic [core_pkg::ALU_OP_W-1:0]   dec_alu_op_o,
  output logic [core_pkg::REG_ADDR_W-1:0] dec_rd_o,
  output logic                            dec_we_o,
  output logic                            dec_is_branch_o,
  output logic                            dec_is_jal_o,
  output logic                            dec_branch_ne_o,
  output logic                            dec_illegal_o,
  output logic                            dec_is_mret_o
);

  core_pkg::instr_t              ins;
  logic [core_pkg::XLEN-1:0]     imm_i, imm_b, imm_j, imm_u, imm;
  logic [core_pkg::ALU_OP_W-1:0] f3_op, alu_op;
  logic                          f3_ok, writes, is_branch, is_jal, is_mret, illegal;

  assign ins          = fetch_instr_i;
  assign rf_raddr_a_o = ins.r.rs1;
  assign rf_raddr_b_o = ins.r.rs2;

  // ----------------------------------------
  // Immediates
  // ----------------------------------------
  assign imm_i = {{20{ins.i.imm[11]}}, ins.i.imm};
  assign imm_u = {ins.i.imm, ins.i.rs1, ins.i.funct3, 12'b0};
  // B and J bits are scattered over both views
  assign imm_b = {{20{ins.r.funct7[6]}}, ins.r.rd[0], ins.r.funct7[5:0], ins.r.rd[4:1], 1'b0};
  assign imm_j = {{12{ins.i.imm[11]}}, ins.i.rs1, ins.i.funct3, ins.i.imm[0],
                  ins.i.imm[10:1], 1'b0};

  // Shared by OP and OP-IMM
  always_comb begin
    f3_ok = 1'b1;
    case (ins.i.funct3)
      core_pkg::F3_ADD_SUB: f3_op = core_pkg::ALU_ADD;
      core_pkg::F3_XOR:     f3_op = core_pkg::ALU_XOR;
      core_pkg::F3_OR:      f3_op = core_pkg::ALU_OR;
      core_pkg::F3_AND:     f3_op = core_pkg::ALU_AND;
      default: begin
        f3_op = core_pkg::ALU_ADD;
        f3_ok = 1'b0;
      end
    endcase
  end

  always_comb begin
    alu_op    = f3_op;
    imm       = imm_i;
    writes    = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_mret   = 1'b0;
    illegal   = 1'b0;
    case (ins.r.opcode)
      core_pkg::OPC_OP_IMM: begin
        writes  = 1'b1;
        illegal = !f3_ok;
      end
      core_pkg::OPC_OP: begin
        writes = 1'b1;
        if (ins.r.funct7 == core_pkg::F7_SUB && ins.r.funct3 == core_pkg::F3_ADD_SUB) begin
          alu_op = core_pkg::ALU_SUB;
        end else begin
          illegal = !f3_ok || ins.r.funct7 != core_pkg::F7_BASE;
        end
      end
      core_pkg::OPC_LUI: begin
        writes = 1'b1;
        imm    = imm_u;
        alu_op = core_pkg::ALU_PASS_B;
      end
      core_pkg::OPC_BRANCH: begin
        imm       = imm_b;
        is_branch = 1'b1;
        illegal   = ins.r.funct3 != core_pkg::F3_BEQ && ins.r.funct3 != core_pkg::F3_BNE;
      end
      core_pkg::OPC_JAL: begin
        writes = 1'b1;
        imm    = imm_j;
        is_jal = 1'b1;
      end
      core_pkg::OPC_SYSTEM: begin
        is_mret = ins == core_pkg::MRET_WORD;
        illegal = !is_mret;
      end
      default: illegal = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= fetch_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_valid_i) begin
      dec_pc_o        <= fetch_pc_i;
      dec_instr_o     <= ins;
      dec_op_a_o      <= rf_rdata_a_i;
      dec_op_b_o      <= rf_rdata_b_i;
      dec_imm_o       <= imm;
      dec_alu_op_o    <= alu_op;
      dec_rd_o        <= ins.r.rd;
      dec_we_o        <= writes && !illegal && ins.r.rd != '0;
      dec_is_branch_o <= is_branch && !illegal;
      dec_is_jal_o    <= is_jal;
      dec_branch_ne_o <= ins.r.funct3 == core_pkg::F3_BNE;
      dec_illegal_o   <= illegal;
      dec_is_mret_o   <= is_mret;
    end
  end

endmodule

/* design/execute_unit.sv */
// Execute stage with ALU and branch resolution
module execute_unit (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            dec_valid_i,
  input  logic [core_pkg::XLEN-1:0]       dec_pc_i,
  input  core_pkg::instr_t                dec_instr_i,
  input  logic [core_pkg::XLEN-1:0]       dec_op_a_i,
  input  logic [core_pkg::XLEN-1:0]       dec_op_b_i,
  input  logic [core_pkg::XLEN-1:0]       dec_imm_i,
  input  logic [core_pkg::ALU_OP_W-1:0]   dec_alu_op_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] dec_rd_i,
  input  logic                            dec_we_i,
  input  logic                            dec_is_branch_i,
  input  logic                            dec_is_jal_i,
  input  logic                            dec_branch_ne_i,
  input  logic                            dec_illegal_i,
  input  logic                            dec_is_mret_i,
  output logic                            ex_valid_o,
  output logic [core_pkg::XLEN-1:0]       ex_pc_o,
  output core_pkg::instr_t                ex_instr_o,
  output logic [core_pkg::XLEN-1:0]       ex_result_o,
  output logic [core_pkg::REG_ADDR_W-1:0] ex_rd_o,
  output logic                            ex_we_o,
  output logic [core_pkg::XLEN-1:0]       ex_next_pc_o,
  output logic                            ex_illegal_o,
  output logic                            ex_is_mret_o
);

  logic [core_pkg::XLEN-1:0] op_b, alu_res, pc_plus4, pc_target;
  logic                      taken;

  // Immediate replaces rs2 except for register-register ops
  assign op_b = (dec_instr_i.r.opcode == core_pkg::OPC_OP) ? dec_op_b_i : dec_imm_i;

  always_comb begin
    case (dec_alu_op_i)
      core_pkg::ALU_ADD: alu_res = dec_op_a_i + op_b;
      core_pkg::ALU_SUB: alu_res = dec_op_a_i - op_b;
      core_pkg::ALU_XOR: alu_res = dec_op_a_i ^ op_b;
      core_pkg::ALU_OR:  alu_res = dec_op_a_i | op_b;
      core_pkg::ALU_AND: alu_res = dec_op_a_i & op_b;
      default:           alu_res = op_b;
    endcase
  end

  // Branch compare always uses both register operands
  assign taken = dec_is_jal_i |
                 (dec_is_branch_i & ((dec_op_a_i == dec_op_b_i) ^ dec_branch_ne_i));
  assign pc_plus4  = dec_pc_i + core_pkg::XLEN'(4);
  assign pc_target = dec_pc_i + dec_imm_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_valid_o <= 1'b0;
    end else begin
      ex_valid_o <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      ex_pc_o      <= dec_pc_i;
      ex_instr_o   <= dec_instr_i;
      ex_result_o  <= dec_is_jal_i ? pc_plus4 : alu_res;
      ex_rd_o      <= dec_rd_i;
      ex_we_o      <= dec_we_i;
      ex_next_pc_o <= taken ? pc_target : pc_plus4;
      ex_illegal_o <= dec_illegal_i;
      ex_is_mret_o <= dec_is_mret_i;
    end
  end

endmodule

/* design/commit_unit.sv */
// Commit stage with writeback and trap handling
module commit_unit #(
  parameter logic [core_pkg::XLEN-1:0] TrapVector = 'h400
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            ex_valid_i,
  input  logic [core_pkg::XLEN-1:0]       ex_pc_i,
  input  core_pkg::instr_t                ex_instr_i,
  input  logic [core_pkg::XLEN-1:0]       ex_result_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] ex_rd_i,
  input  logic                            ex_we_i,
  input  logic [core_pkg::XLEN-1:0]       ex_next_pc_i,
  input  logic                            ex_illegal_i,
  input  logic                            ex_is_mret_i,
  output logic                            rf_we_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [core_pkg::XLEN-1:0]       rf_wdata_o,
  output logic                            redirect_valid_o,
  output logic [core_pkg::XLEN-1:0]       redirect_pc_o,
  output logic                            commit_valid_o,
  output logic [core_pkg::XLEN-1:0]       commit_pc_o,
  output logic [31:0]                     commit_insn_o,
  output logic                            commit_we_o,
  output logic [core_pkg::REG_ADDR_W-1:0] commit_rd_o,
  output logic [core_pkg::XLEN-1:0]       commit_wdata_o,
  output logic                            commit_exc_o,
  output logic [core_pkg::XLEN-1:0]       commit_cause_o
);

  logic [core_pkg::XLEN-1:0] epc_q;
  logic                      trap;

  // Retire point is the cycle the execute result is held
  assign trap       = ex_valid_i & ex_illegal_i;
  assign rf_we_o    = ex_valid_i & ex_we_i & ~ex_illegal_i;
  assign rf_waddr_o = ex_rd_i;
  assign rf_wdata_o = ex_result_i;

  // Trace port
  assign commit_valid_o = ex_valid_i;
  assign commit_pc_o    = ex_pc_i;
  assign commit_insn_o  = ex_instr_i;
  assign commit_we_o    = rf_we_o;
  assign commit_rd_o    = ex_rd_i;
  assign commit_wdata_o = ex_result_i;
  assign commit_exc_o   = trap;
  assign commit_cause_o = trap ? core_pkg::CAUSE_ILLEGAL : '0;

  // Every commit restarts fetch somewhere
  assign redirect_valid_o = ex_valid_i;

  always_comb begin
    if (ex_illegal_i) begin
      redirect_pc_o = TrapVector;
    end else if (ex_is_mret_i) begin
      redirect_pc_o = epc_q + core_pkg::XLEN'(4); // handler skips the faulting word
    end else begin
      redirect_pc_o = ex_next_pc_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      epc_q <= '0;
    end else if (trap) begin
      epc_q <= ex_pc_i;
    end
  end

endmodule

/* design/core_top.sv */
// RV32 integer core top level
module core_top #(
  parameter logic [core_pkg::XLEN-1:0] BootAddr   = '0,
  parameter logic [core_pkg::XLEN-1:0] TrapVector = 'h400
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  output logic                            instr_req_o,
  output logic [core_pkg::XLEN-1:0]       instr_addr_o,
  input  logic                            instr_valid_i,
  input  logic [31:0]                     instr_rdata_i,
  output logic                            commit_valid_o,
  output logic [core_pkg::XLEN-1:0]       commit_pc_o,
  output logic [31:0]                     commit_insn_o,
  output logic                            commit_we_o,
  output logic [core_pkg::REG_ADDR_W-1:0] commit_rd_o,
  output logic [core_pkg::XLEN-1:0]       commit_wdata_o,
  output logic                            commit_exc_o,
  output logic [core_pkg::XLEN-1:0]       commit_cause_o
);

  // ----------------------------------------
  // Stage signals
  // ----------------------------------------
  logic                            fetch_valid, dec_valid, ex_valid, redirect_valid, rf_we;
  logic [core_pkg::XLEN-1:0]       fetch_pc, dec_pc, ex_pc, redirect_pc;
  core_pkg::instr_t                fetch_instr, dec_instr, ex_instr;
  logic [core_pkg::REG_ADDR_W-1:0] rf_raddr_a, rf_raddr_b, rf_waddr, dec_rd, ex_rd;
  logic [core_pkg::XLEN-1:0]       rf_rdata_a, rf_rdata_b, rf_wdata;
  logic [core_pkg::XLEN-1:0]       dec_op_a, dec_op_b, dec_imm, ex_result, ex_next_pc;
  logic [core_pkg::ALU_OP_W-1:0]   dec_alu_op;
  logic                            dec_we, dec_is_branch, dec_is_jal, dec_branch_ne;
  logic                            dec_illegal, dec_is_mret, ex_we, ex_illegal, ex_is_mret;

  fetch_unit #(
    .BootAddr (BootAddr)
  ) u_fetch_unit (
    .clk_i,
    .rst_ni,
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .instr_req_o,
    .instr_addr_o,
    .instr_valid_i,
    .instr_rdata_i,
    .fetch_valid_o    (fetch_valid),
    .fetch_pc_o       (fetch_pc),
    .fetch_instr_o    (fetch_instr)
  );

  reg_file u_reg_file (
    .clk_i,
    .rst_ni,
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  decode_unit u_decode_unit (
    .clk_i,
    .rst_ni,
    .fetch_valid_i   (fetch_valid),
    .fetch_pc_i      (fetch_pc),
    .fetch_instr_i   (fetch_instr),
    .rf_raddr_a_o    (rf_raddr_a),
    .rf_raddr_b_o    (rf_raddr_b),
    .rf_rdata_a_i    (rf_rdata_a),
    .rf_rdata_b_i    (rf_rdata_b),
    .dec_valid_o     (dec_valid),
    .dec_pc_o        (dec_pc),
    .dec_instr_o     (dec_instr),
    .dec_op_a_o      (dec_op_a),
    .dec_op_b_o      (dec_op_b),
    .dec_imm_o       (dec_imm),
    .dec_alu_op_o    (dec_alu_op),
    .dec_rd_o        (dec_rd),
    .dec_we_o        (dec_we),
    .dec_is_branch_o (dec_is_branch),
    .dec_is_jal_o    (dec_is_jal),
    .dec_branch_ne_o (dec_branch_ne),
    .dec_illegal_o   (dec_illegal),
    .dec_is_mret_o   (dec_is_mret)
  );

  execute_unit u_execute_unit (
    .clk_i,
    .rst_ni,
    .dec_valid_i     (dec_valid),
    .dec_pc_i        (dec_pc),
    .dec_instr_i     (dec_instr),
    .dec_op_a_i      (dec_op_a),
    .dec_op_b_i      (dec_op_b),
    .dec_imm_i       (dec_imm),
    .dec_alu_op_i    (dec_alu_op),
    .dec_rd_i        (dec_rd),
    .dec_we_i        (dec_we),
    .dec_is_branch_i (dec_is_branch),
    .dec_is_jal_i    (dec_is_jal),
    .dec_branch_ne_i (dec_branch_ne),
    .dec_illegal_i   (dec_illegal),
    .dec_is_mret_i   (dec_is_mret),
    .ex_valid_o      (ex_valid),
    .ex_pc_o         (ex_pc),
    .ex_instr_o      (ex_instr),
    .ex_result_o     (ex_result),
    .ex_rd_o         (ex_rd),
    .ex_we_o         (ex_we),
    .ex_next_pc_o    (ex_next_pc),
    .ex_illegal_o    (ex_illegal),
    .ex_is_mret_o    (ex_is_mret)
  );

  commit_unit #(
    .TrapVector (TrapVector)
  ) u_commit_unit (
    .clk_i,
    .rst_ni,
    .ex_valid_i       (ex_valid),
    .ex_pc_i          (ex_pc),
    .ex_instr_i       (ex_instr),
    .ex_result_i      (ex_result),
    .ex_rd_i          (ex_rd),
    .ex_we_i          (ex_we),
    .ex_next_pc_i     (ex_next_pc),
    .ex_illegal_i     (ex_illegal),
    .ex_is_mret_i     (ex_is_mret),
    .rf_we_o          (rf_we),
    .rf_waddr_o       (rf_waddr),
    .rf_wdata_o       (rf_wdata),
    .redirect_valid_o (redirect_valid),
    .redirect_pc_o    (redirect_pc),
    .commit_valid_o,
    .commit_pc_o,
    .commit_insn_o,
    .commit_we_o,
    .commit_rd_o,
    .commit_wdata_o,
    .commit_exc_o,
    .commit_cause_o
  );

endmodule

/* test/tb_iss.svh */
// Reference ISA model and program generator
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

logic [31:0] prog [PROG_LEN];
logic [31:0] model_regs [32];
logic [31:0] model_pc;
logic [31:0] model_epc;

// ----------------------------------------
// Encoders
// ----------------------------------------
function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

// Program memory plus the MRET at the trap vector
function automatic logic [31:0] mem_read(input logic [31:0] addr);
  if (addr == TRAP_VEC) begin
    return MRET;
  end
  if (addr < 32'(PROG_LEN * 4)) begin
    return prog[int'(addr >> 2)];
  end
  return ~addr;
endfunction

task automatic build_program();
  int unsigned illegal_left;
  int unsigned kind;
  int unsigned span;
  logic [4:0]  rd, rs1, rs2;
  logic [2:0]  f3;
  logic [2:0]  f3_set [4];
  f3_set       = '{3'b000, 3'b100, 3'b110, 3'b111};
  illegal_left = 8;
  for (int i = 0; i < PROG_LEN - 1; i++) begin
    kind = $urandom_range(15, 0);
    // Registers x0 to x7 only so results get reused
    rd   = 5'($urandom_range(7, 0));
    rs1  = 5'($urandom_range(7, 0));
    rs2  = 5'($urandom_range(7, 0));
    f3   = f3_set[$urandom_range(3, 0)];
    span = $urandom_range(4, 1);
    if (i + int'(span) > PROG_LEN - 1) begin
      span = PROG_LEN - 1 - i;
    end
    case (kind)
      0, 1, 2, 3, 4: prog[i] = i_word(12'($urandom), rs1, f3, rd, 7'b0010011);
      5, 6, 7, 8: begin
        if ($urandom_range(3, 0) == 0) begin
          prog[i] = r_word(7'b0100000, rs2, rs1, 3'b000, rd);
        end else begin
          prog[i] = r_word(7'b0000000, rs2, rs1, f3, rd);
        end
      end
      9:      prog[i] = {20'($urandom), rd, 7'b0110111};
      10, 11: prog[i] = b_word(13'(span * 4), rs2, rs1, {2'b00, kind[0]});
      12:     prog[i] = j_word(21'(span * 4), rd);
      13: begin
        if (illegal_left > 0) begin
          illegal_left--;
          case ($urandom_range(3, 0))
            0:       prog[i] = i_word(12'h10, rs1, 3'b010, rd, 7'b0000011);
            1:       prog[i] = i_word(12'h3, rs1, 3'b001, rd, 7'b0010011);
            2:       prog[i] = r_word(7'b0000001, rs2, rs1, 3'b000, rd);
            default: prog[i] = 32'h0;
          endcase
        end else begin
          prog[i] = i_word(12'h7, rs1, 3'b000, rd, 7'b0010011);
        end
      end
      default: prog[i] = i_word(12'($urandom), 5'd0, 3'b000, rd, 7'b0010011);
    endcase
  end
  prog[PROG_LEN - 1] = HALT_WORD;
endtask

task automatic reset_model();
  for (int r = 0; r < 32; r++) begin
    model_regs[r] = 32'h0;
  end
  model_pc  = BOOT_ADDR;
  model_epc = 32'h0;
endtask

// One instruction on the architectural state
task automatic step_model(input logic [31:0] w, output logic we, output logic [4:0] rd,
                          output logic [31:0] wdata, output logic exc);
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [31:0] a, b, imm_i, imm_b, imm_j, next_pc;
  logic        legal;
  f3      = w[14:12];
  f7      = w[31:25];
  rd      = w[11:7];
  a       = model_regs[w[19:15]];
  b       = model_regs[w[24:20]];
  imm_i   = {{20{w[31]}}, w[31:20]};
  imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  imm_j   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
  next_pc = model_pc + 32'd4;
  we      = 1'b1;
  wdata   = 32'h0;
  legal   = 1'b1;
  case (w[6:0])
    7'b0010011, 7'b0110011: begin
      if (w[6:0] == 7'b0110011 && f7 == 7'b0100000 && f3 == 3'b000) begin
        wdata = a - b;
      end else begin
        if (w[6:0] == 7'b0110011) begin
          legal = (f7 == 7'b0000000);
        end else begin
          b = imm_i;
        end
        case (f3)
          3'b000:  wdata = a + b;
          3'b100:  wdata = a ^ b;
          3'b110:  wdata = a | b;
          3'b111:  wdata = a & b;
          default: legal = 1'b0;
        endcase
      end
    end
    7'b0110111: wdata = {w[31:12], 12'h0};
    7'b1100011: begin
      we    = 1'b0;
      legal = (f3 == 3'b000 || f3 == 3'b001);
      if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
        next_pc = model_pc + imm_b;
      end
    end
    7'b1101111: begin
      wdata   = model_pc + 32'd4;
      next_pc = model_pc + imm_j;
    end
    7'b1110011: begin
      we      = 1'b0;
      legal   = (w == MRET);
      next_pc = model_epc + 32'd4;
    end
    default: legal = 1'b0;
  endcase
  exc = !legal;
  if (!legal) begin
    we        = 1'b0;
    model_epc = model_pc;
    next_pc   = TRAP_VEC;
  end
  if (rd == 5'd0) begin
    we = 1'b0;
  end
  if (we) begin
    model_regs[rd] = wdata;
  end
  model_pc = next_pc;
endtask

`endif

/* test/tb_core.sv */
// Core testbench
module tb_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] BOOT_ADDR     = 32'h0;
  localparam logic [31:0] TRAP_VEC      = 32'h400;
  localparam int          PROG_LEN      = 64;
  localparam logic [31:0] HALT_WORD     = 32'h0000_006f;
  localparam logic [31:0] HALT_PC       = 32'((PROG_LEN - 1) * 4);
  localparam logic [31:0] MRET          = 32'h3020_0073;
  localparam logic [31:0] CAUSE_ILLEGAL = 32'd2;
  // About 8 cycles per commit at most with trap returns included
  localparam int          TIMEOUT_CYCLES = PROG_LEN * 10;

  logic        clk_i;
  logic        rst_ni;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        instr_valid_i;
  logic [31:0] instr_rdata_i;
  logic        commit_valid_o;
  logic [31:0] commit_pc_o;
  logic [31:0] commit_insn_o;
  logic        commit_we_o;
  logic [4:0]  commit_rd_o;
  logic [31:0] commit_wdata_o;
  logic        commit_exc_o;
  logic [31:0] commit_cause_o;

  int          cyc;
  int          resp_cycle;
  int          last_commit_cycle;
  int          wait_left;
  logic        pending;
  logic        first_req_seen;
  logic        halted;
  logic [31:0] req_addr;
  int unsigned mismatch_errors;
  int unsigned protocol_errors;

  `include "tb_iss.svh"

  core_top #(
    .BootAddr   (BOOT_ADDR),
    .TrapVector (TRAP_VEC)
  ) u_core_top (
    .clk_i,
    .rst_ni,
    .instr_req_o,
    .instr_addr_o,
    .instr_valid_i,
    .instr_rdata_i,
    .commit_valid_o,
    .commit_pc_o,
    .commit_insn_o,
    .commit_we_o,
    .commit_rd_o,
    .commit_wdata_o,
    .commit_exc_o,
    .commit_cause_o
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      mismatch_errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // ----------------------------------------
  // Memory model and commit checks
  // ----------------------------------------
  task automatic monitor_cycle();
    logic        exp_req, exp_we, exp_exc;
    logic [4:0]  exp_rd;
    logic [31:0] exp_wdata, exp_pc, word;
    // Pending response goes first so a new request waits at least one cycle
    instr_valid_i = 1'b0;
    if (pending) begin
      wait_left--;
      if (wait_left == 0) begin
        instr_valid_i = 1'b1;
        instr_rdata_i = mem_read(req_addr);
        resp_cycle    = cyc;
        pending       = 1'b0;
      end
    end

    exp_req = (cyc == 1) || (last_commit_cycle == cyc - 1);
    assert (instr_req_o == exp_req) else begin
      protocol_errors++;
      $display("Request line is %0b in cycle %0d, last commit was in cycle %0d",
               instr_req_o, cyc, last_commit_cycle);
    end
    if (instr_req_o) begin
      assert (!pending) else begin
        protocol_errors++;
        $display("Second request in cycle %0d while one is outstanding", cyc);
      end
      if (!first_req_seen) begin
        check_value("instr_addr_o", instr_addr_o, BOOT_ADDR);
        first_req_seen = 1'b1;
      end
      assert (instr_addr_o == TRAP_VEC || instr_addr_o < 32'(PROG_LEN * 4)) else begin
        protocol_errors++;
        $display("Fetch from address %h outside the program", instr_addr_o);
      end
      pending   = 1'b1;
      req_addr  = instr_addr_o;
      wait_left = int'($urandom_range(4, 1));
    end

    if (commit_valid_o) begin
      assert (cyc == resp_cycle + 3) else begin
        protocol_errors++;
        $display("Commit in cycle %0d is not 3 cycles after the response in cycle %0d",
                 cyc, resp_cycle);
      end
      exp_pc = model_pc;
      word   = mem_read(exp_pc);
      step_model(word, exp_we, exp_rd, exp_wdata, exp_exc);
      check_value("commit_pc_o", commit_pc_o, exp_pc);
      check_value("commit_insn_o", commit_insn_o, word);
      check_value("commit_we_o", 32'(commit_we_o), 32'(exp_we));
      if (exp_we) begin
        check_value("commit_rd_o", 32'(commit_rd_o), 32'(exp_rd));
        check_value("commit_wdata_o", commit_wdata_o, exp_wdata);
      end
      check_value("commit_exc_o", 32'(commit_exc_o), 32'(exp_exc));
      if (exp_exc) begin
        check_value("commit_cause_o", commit_cause_o, CAUSE_ILLEGAL);
      end
      last_commit_cycle = cyc;
      if (exp_pc == HALT_PC) begin
        halted = 1'b1;
      end
    end
  endtask

  initial begin
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_rdata_i     = 32'h0;
    cyc               = 0;
    resp_cycle        = -8;
    last_commit_cycle = -8;
    wait_left         = 0;
    pending           = 1'b0;
    first_req_seen    = 1'b0;
    halted            = 1'b0;
    req_addr          = 32'h0;
    mismatch_errors   = 0;
    protocol_errors   = 0;
    void'($urandom(32'h1b0a));
    build_program();
    reset_model();

    repeat (2) @(negedge clk_i);
    // Quiet outputs and stage strobes while held in reset
    check_value("instr_req_o", 32'(instr_req_o), 32'h0);
    check_value("commit_valid_o", 32'(commit_valid_o), 32'h0);
    check_value("commit_we_o", 32'(commit_we_o), 32'h0);
    check_value("commit_exc_o", 32'(commit_exc_o), 32'h0);
    check_value("fetch_valid", 32'(u_core_top.fetch_valid), 32'h0);
    check_value("dec_valid", 32'(u_core_top.dec_valid), 32'h0);
    check_value("ex_valid", 32'(u_core_top.ex_valid), 32'h0);
    rst_ni = 1'b1;

    while (!halted && cyc < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cyc++;
      monitor_cycle();
    end

    if (!halted) begin
      protocol_errors++;
      $display("Run stopped after %0d cycles before the program reached its end", cyc);
    end
    $display("Errors: %0d mismatches, %0d protocol failures",
             mismatch_errors, protocol_errors);
    if (mismatch_errors == 0 && protocol_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+test
design/core_pkg.sv
design/fetch_unit.sv
design/reg_file.sv
design/decode_unit.sv
design/execute_unit.sv
design/commit_unit.sv
design/core_top.sv
test/tb_core.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps -Wno-fatal \
  --top-module tb_core -Mdir obj_dir -f files.f > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/Vtb_core > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "SIMULATION PASSED" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1
